// File: ddr2_front_pkg.sv
package ddr2_front_pkg;

	// pin command encoding, {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		MRST = 3'b000, // mode register set
		ARSR = 3'b001, // auto refresh
		PRCH = 3'b010, // precharge
		ACTV = 3'b011, // activate row
		WRTE = 3'b100,
		READ = 3'b101,
		BTRM = 3'b110, // burst terminate
		NOOP = 3'b111
	} ddr2_cmd_e;

	localparam int CKE_WAIT_CYCLES    = 512;
	localparam int INIT_STEP_CYCLES   = 32;
	localparam int INIT_SETTLE_CYCLES = 256;
	localparam int INIT_STEPS         = 11;
	localparam int REFRESH_INTERVAL   = 780;
	localparam int TRP_CYCLES         = 4;
	localparam int TRFC_CYCLES        = 16;
	localparam int QUEUE_DEPTH        = 4;

	// counter and pointer widths
	localparam int INIT_CNT_W = $clog2(CKE_WAIT_CYCLES);
	localparam int STEP_W     = $clog2(INIT_STEPS);
	localparam int REF_CNT_W  = $clog2(REFRESH_INTERVAL);
	localparam int HOLD_CNT_W = $clog2(TRFC_CYCLES);
	localparam int QPTR_W     = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W     = QPTR_W + 1;

	typedef struct packed {
		ddr2_cmd_e   cmd;
		logic [2:0]  bank;
		logic [13:0] addr;
	} init_step_t;

	localparam init_step_t INIT_SEQ [INIT_STEPS] = '{
		'{PRCH, 3'd1, 14'h400}, // precharge all
		'{MRST, 3'd2, 14'h000}, // emr2
		'{MRST, 3'd3, 14'h000}, // emr3
		'{MRST, 3'd1, 14'h780}, // emr, ocd default
		'{MRST, 3'd0, 14'h532}, // mr with dll reset
		'{PRCH, 3'd0, 14'h400},
		'{ARSR, 3'd0, 14'h400},
		'{ARSR, 3'd0, 14'h400},
		'{MRST, 3'd0, 14'h432}, // mr, dll reset cleared
		'{MRST, 3'd1, 14'h780},
		'{MRST, 3'd1, 14'h400}  // emr, ocd exit
	};

endpackage

// File: ddr2_cmd_if.sv
`timescale 1ns/100ps

interface ddr2_cmd_if;

	logic                      cke;
	ddr2_front_pkg::ddr2_cmd_e cmd;
	logic [13:0]               addr;
	logic [2:0]                bank;
	logic                      done; // init finished, stays high

	modport source (
		output cke,
		output cmd,
		output addr,
		output bank,
		output done
	);

	modport sink (
		input cke,
		input cmd,
		input addr,
		input bank,
		input done
	);

endinterface

// File: ddr2_initializer.sv
`timescale 1ns/100ps

module ddr2_initializer (
	input  logic       CLK_n,
	input  logic       RST,
	ddr2_cmd_if.source init
);

	typedef enum logic [1:0] {
		PH_CKE_WAIT,
		PH_STEP,
		PH_SETTLE,
		PH_DONE
	} phase_e;

	phase_e                                phase;
	logic [ddr2_front_pkg::INIT_CNT_W-1:0] cnt; // shared by every phase
	logic [ddr2_front_pkg::STEP_W-1:0]     step; // index into the sequence table
	logic                                  cnt_hit;

	// terminal count of the current phase
	always_comb begin
		case (phase)
			PH_CKE_WAIT: begin
				cnt_hit = (cnt == ddr2_front_pkg::INIT_CNT_W'(
					ddr2_front_pkg::CKE_WAIT_CYCLES - 1));
			end
			PH_STEP: begin
				cnt_hit = (cnt == ddr2_front_pkg::INIT_CNT_W'(
					ddr2_front_pkg::INIT_STEP_CYCLES - 1));
			end
			PH_SETTLE: begin
				cnt_hit = (cnt == ddr2_front_pkg::INIT_CNT_W'(
					ddr2_front_pkg::INIT_SETTLE_CYCLES - 1));
			end
			default: begin
				cnt_hit = 1'b0;
			end
		endcase
	end

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			phase     <= PH_CKE_WAIT;
			cnt       <= '0;
			step      <= '0;
			init.cke  <= 1'b0;
			init.cmd  <= ddr2_front_pkg::NOOP;
			init.addr <= '0;
			init.bank <= '0;
			init.done <= 1'b0;
		end else begin
			init.cmd <= ddr2_front_pkg::NOOP; // idle between steps

			if (phase != PH_DONE) begin
				if (cnt_hit) begin
					cnt <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end

			if (cnt_hit) begin
				case (phase)
					PH_CKE_WAIT: begin
						init.cke <= 1'b1; // clock stable, leave power down
						phase    <= PH_STEP;
					end
					PH_STEP: begin
						init.cmd  <= ddr2_front_pkg::INIT_SEQ[step].cmd;
						init.addr <= ddr2_front_pkg::INIT_SEQ[step].addr;
						init.bank <= ddr2_front_pkg::INIT_SEQ[step].bank;
						if (step == ddr2_front_pkg::STEP_W'(ddr2_front_pkg::INIT_STEPS - 1)) begin
							phase <= PH_SETTLE;
						end else begin
							step <= step + 1'b1;
						end
					end
					PH_SETTLE: begin
						init.done <= 1'b1; // hand the pins to the arbiter
						phase     <= PH_DONE;
					end
					default: begin
						phase <= PH_DONE;
					end
				endcase
			end
		end
	end

	// every sequence command is followed by a full gap of NOOPs
	a_step_spacing: assert property (
		@(posedge CLK_n) disable iff (!RST)
		(init.cke && init.cmd != ddr2_front_pkg::NOOP) |=>
			(init.cmd == ddr2_front_pkg::NOOP) [*(ddr2_front_pkg::INIT_STEP_CYCLES - 1)]
	);

	// nothing but NOOP while cke is still low
	a_noop_before_cke: assert property (
		@(posedge CLK_n) disable iff (!RST)
		!init.cke |-> init.cmd == ddr2_front_pkg::NOOP
	);

endmodule

// File: ddr2_refresh_timer.sv
`timescale 1ns/100ps

module ddr2_refresh_timer (
	input  logic CLK_n,
	input  logic RST,
	input  logic enable,
	output logic refresh_req,
	input  logic refresh_ack
);

	logic [ddr2_front_pkg::REF_CNT_W-1:0] interval_cnt;
	logic                                 expired;

	assign expired = (interval_cnt == ddr2_front_pkg::REF_CNT_W'(
		ddr2_front_pkg::REFRESH_INTERVAL - 1));

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			interval_cnt <= '0;
			refresh_req  <= 1'b0;
		end else if (refresh_ack) begin
			interval_cnt <= '0; // next interval starts at the ack
			refresh_req  <= 1'b0;
		end else if (enable && !refresh_req) begin
			if (expired) begin
				interval_cnt <= '0;
				refresh_req  <= 1'b1; // held until acknowledged
			end else begin
				interval_cnt <= interval_cnt + 1'b1;
			end
		end
	end

	// a request is only withdrawn by the arbiter's ack
	a_req_sticky: assert property (
		@(posedge CLK_n) disable iff (!RST)
		$fell(refresh_req) |-> $past(refresh_ack)
	);

endmodule

// File: ddr2_cmd_arbiter.sv
`timescale 1ns/100ps

module ddr2_cmd_arbiter (
	input  logic                      CLK_n,
	input  logic                      RST,
	ddr2_cmd_if.sink                  init,
	input  logic                      refresh_req,
	output logic                      refresh_ack,
	input  logic                      user_valid,
	input  ddr2_front_pkg::ddr2_cmd_e user_cmd,
	input  logic [13:0]               user_addr,
	input  logic [2:0]                user_bank,
	output logic                      credit_return,
	output logic                      ready,
	output logic                      cke,
	output ddr2_front_pkg::ddr2_cmd_e cmd_pin,
	output logic [13:0]               addr_pin,
	output logic [2:0]                bank_pin
);

	typedef enum logic [2:0] {
		R_IDLE,
		R_PRCH,
		R_TRP,
		R_ARSR,
		R_TRFC,
		R_ACK
	} ref_state_e;

	ref_state_e                            rstate;
	logic [ddr2_front_pkg::HOLD_CNT_W-1:0] hold_cnt; // trp and trfc spacing

	ddr2_front_pkg::ddr2_cmd_e           q_cmd  [ddr2_front_pkg::QUEUE_DEPTH];
	logic [13:0]                         q_addr [ddr2_front_pkg::QUEUE_DEPTH];
	logic [2:0]                          q_bank [ddr2_front_pkg::QUEUE_DEPTH];
	logic [ddr2_front_pkg::QPTR_W-1:0]   wr_ptr;
	logic [ddr2_front_pkg::QPTR_W-1:0]   rd_ptr;
	logic [ddr2_front_pkg::QCNT_W-1:0]   count;
	logic                                full;
	logic                                empty;
	logic                                accept;
	logic                                issue;
	logic                                issue_d; // queued command now on the pins

	ddr2_front_pkg::ddr2_cmd_e nxt_cmd;
	logic [13:0]               nxt_addr;
	logic [2:0]                nxt_bank;

	assign full        = (count == ddr2_front_pkg::QCNT_W'(ddr2_front_pkg::QUEUE_DEPTH));
	assign empty       = (count == '0);
	assign accept      = user_valid && ready && !full;
	assign issue       = ready && (rstate == R_IDLE) && !refresh_req && !empty;
	assign refresh_ack = (rstate == R_ACK);

	// next pin word, initializer until done, then refresh or queue head
	always_comb begin
		nxt_cmd  = ddr2_front_pkg::NOOP;
		nxt_addr = addr_pin; // hold address lines on NOOP
		nxt_bank = bank_pin;
		if (!init.done) begin
			nxt_cmd  = init.cmd;
			nxt_addr = init.addr;
			nxt_bank = init.bank;
		end else if (rstate == R_PRCH) begin
			nxt_cmd  = ddr2_front_pkg::PRCH;
			nxt_addr = 14'h400; // a10 high, all banks
			nxt_bank = 3'd0;
		end else if (rstate == R_ARSR) begin
			nxt_cmd = ddr2_front_pkg::ARSR;
		end else if (issue) begin
			nxt_cmd  = q_cmd[rd_ptr];
			nxt_addr = q_addr[rd_ptr];
			nxt_bank = q_bank[rd_ptr];
		end
	end

	always_ff @(posedge CLK_n) begin
		if (accept) begin
			q_cmd[wr_ptr]  <= user_cmd;
			q_addr[wr_ptr] <= user_addr;
			q_bank[wr_ptr] <= user_bank;
		end
	end

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			cke           <= 1'b0;
			cmd_pin       <= ddr2_front_pkg::NOOP;
			addr_pin      <= '0;
			bank_pin      <= '0;
			ready         <= 1'b0;
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			issue_d       <= 1'b0;
			credit_return <= 1'b0;
			rstate        <= R_IDLE;
			hold_cnt      <= '0;
		end else begin
			cke           <= init.cke;
			cmd_pin       <= nxt_cmd;
			addr_pin      <= nxt_addr;
			bank_pin      <= nxt_bank;
			ready         <= init.done;
			issue_d       <= issue;
			credit_return <= issue_d; // one cycle behind the pin

			if (accept) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (issue) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (accept && !issue) begin
				count <= count + 1'b1;
			end else if (issue && !accept) begin
				count <= count - 1'b1;
			end

			case (rstate)
				R_IDLE: begin
					if (refresh_req) begin
						rstate <= R_PRCH; // queue stalls from here
					end
				end
				R_PRCH: begin
					hold_cnt <= '0;
					rstate   <= R_TRP;
				end
				R_TRP: begin
					if (hold_cnt == ddr2_front_pkg::HOLD_CNT_W'(ddr2_front_pkg::TRP_CYCLES - 1)) begin
						hold_cnt <= '0;
						rstate   <= R_ARSR;
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end
				R_ARSR: begin
					rstate <= R_TRFC;
				end
				R_TRFC: begin
					if (hold_cnt == ddr2_front_pkg::HOLD_CNT_W'(ddr2_front_pkg::TRFC_CYCLES - 1)) begin
						hold_cnt <= '0;
						rstate   <= R_ACK;
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end
				default: begin
					rstate <= R_IDLE; // ack cycle
				end
			endcase
		end
	end

	// the user side spends credits, so it never finds the queue full
	a_no_overflow: assert property (
		@(posedge CLK_n) disable iff (!RST)
		user_valid |-> !full
	);

	// no user traffic while the initializer owns the pins
	a_valid_after_ready: assert property (
		@(posedge CLK_n) disable iff (!RST)
		user_valid |-> ready
	);

endmodule

// File: ddr2_front.sv
`timescale 1ns/100ps

module ddr2_front (
	input  logic                      CLK_n,
	input  logic                      RST,
	input  logic                      user_valid,
	input  ddr2_front_pkg::ddr2_cmd_e user_cmd,
	input  logic [13:0]               user_addr,
	input  logic [2:0]                user_bank,
	output logic                      credit_return,
	output logic                      ready,
	output logic                      cke,
	output ddr2_front_pkg::ddr2_cmd_e cmd_pin,
	output logic [13:0]               addr_pin,
	output logic [2:0]                bank_pin
);

	ddr2_cmd_if init_bus ();

	logic refresh_req;
	logic refresh_ack;

	ddr2_initializer u_init (
		.CLK_n (CLK_n),
		.RST   (RST),
		.init  (init_bus)
	);

	// refresh interval only runs once init is done
	ddr2_refresh_timer u_refresh (
		.CLK_n       (CLK_n),
		.RST         (RST),
		.enable      (init_bus.done),
		.refresh_req (refresh_req),
		.refresh_ack (refresh_ack)
	);

	ddr2_cmd_arbiter u_arb (
		.CLK_n         (CLK_n),
		.RST           (RST),
		.init          (init_bus),
		.refresh_req   (refresh_req),
		.refresh_ack   (refresh_ack),
		.user_valid    (user_valid),
		.user_cmd      (user_cmd),
		.user_addr     (user_addr),
		.user_bank     (user_bank),
		.credit_return (credit_return),
		.ready         (ready),
		.cke           (cke),
		.cmd_pin       (cmd_pin),
		.addr_pin      (addr_pin),
		.bank_pin      (bank_pin)
	);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic CLK_n
);

	initial begin
		CLK_n = 1'b0;
	end

	always begin
		#4 CLK_n = ~CLK_n; // 8 ns period
	end

endmodule

// File: tb_ddr2_front.sv
`timescale 1ns/100ps

module tb_ddr2_front;

	localparam int WAIT_LIMIT    = 2000;
	localparam int STREAM_CYCLES = 1600;
	localparam int EXTRA_CREDITS = 8;

	logic                      CLK_n;
	logic                      RST;
	logic                      user_valid;
	ddr2_front_pkg::ddr2_cmd_e user_cmd;
	logic [13:0]               user_addr;
	logic [2:0]                user_bank;
	logic                      credit_return;
	logic                      ready;
	logic                      cke;
	ddr2_front_pkg::ddr2_cmd_e cmd_pin;
	logic [13:0]               addr_pin;
	logic [2:0]                bank_pin;

	int          errors;
	int          test_err [6];
	int          tests_done;
	int          cycle; // clock edges since reset release
	int          credits;
	int          sent;
	int          returned;
	int          cke_cycle  = -1;
	int          last_step;
	int          step_idx;
	int          prch_cycle = -1;
	int          arsr_cycle = -1;
	int          refreshes;
	logic        in_refresh = 1'b0;
	logic        ready_seen = 1'b0;
	logic [19:0] pin_word;
	logic [19:0] expect_q [$]; // {cmd, bank, addr} in send order

	tb_clock_gen clk_gen (.CLK_n(CLK_n));

	ddr2_front uut (.*);

	// power-up table, {cmd, bank, addr}
	function automatic logic [19:0] init_word(input int idx);
		case (idx)
			0: return {ddr2_front_pkg::PRCH, 3'd1, 14'h400};
			1: return {ddr2_front_pkg::MRST, 3'd2, 14'h000};
			2: return {ddr2_front_pkg::MRST, 3'd3, 14'h000};
			3: return {ddr2_front_pkg::MRST, 3'd1, 14'h780};
			4: return {ddr2_front_pkg::MRST, 3'd0, 14'h532};
			5: return {ddr2_front_pkg::PRCH, 3'd0, 14'h400};
			6: return {ddr2_front_pkg::ARSR, 3'd0, 14'h400};
			7: return {ddr2_front_pkg::ARSR, 3'd0, 14'h400};
			8: return {ddr2_front_pkg::MRST, 3'd0, 14'h432};
			9: return {ddr2_front_pkg::MRST, 3'd1, 14'h780};
			default: return {ddr2_front_pkg::MRST, 3'd1, 14'h400};
		endcase
	endfunction

	task automatic value_error(input int t, input string name, input int exp, input int act);
		$display("Error %s: expected %0h, actual %0h", name, exp, act);
		errors++;
		test_err[t]++;
	endtask

	task automatic fault(input int t, input string what);
		$display("Failure at %0t: %s", $time, what);
		errors++;
		test_err[t]++;
	endtask

	task automatic report_test(input int t, input string name);
		tests_done++;
		if (test_err[t] == 0) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, test_err[t]);
		end
	endtask

	task automatic check_init_step();
		int gap;
		gap = (step_idx == 0) ? cycle - cke_cycle : cycle - last_step;
		if (step_idx >= ddr2_front_pkg::INIT_STEPS) begin
			fault(1, "command after the last init step");
		end else begin
			assert (pin_word == init_word(step_idx))
				else value_error(1, $sformatf("init_sequence step %0d", step_idx + 1),
					init_word(step_idx), pin_word);
			assert (gap == ddr2_front_pkg::INIT_STEP_CYCLES)
				else value_error(1, $sformatf("init_sequence step %0d spacing", step_idx + 1),
					ddr2_front_pkg::INIT_STEP_CYCLES, gap);
			step_idx++;
			last_step = cycle;
		end
	endtask

	task automatic check_user_side();
		logic [19:0] want;
		case (cmd_pin)
			ddr2_front_pkg::PRCH: begin
				assert (addr_pin == 14'h400)
					else value_error(4, "refresh precharge address", 'h400, addr_pin);
				in_refresh = 1'b1;
				prch_cycle = cycle;
				arsr_cycle = -1;
			end
			ddr2_front_pkg::ARSR: begin
				if (!in_refresh) begin
					fault(4, "auto refresh without a precharge before it");
				end else begin
					assert (cycle - prch_cycle > ddr2_front_pkg::TRP_CYCLES)
						else value_error(4, "refresh trp gap", ddr2_front_pkg::TRP_CYCLES + 1,
							cycle - prch_cycle);
				end
				arsr_cycle = cycle;
				refreshes++;
			end
			ddr2_front_pkg::ACTV, ddr2_front_pkg::READ, ddr2_front_pkg::WRTE,
			ddr2_front_pkg::BTRM: begin
				if (in_refresh) begin
					fault(4, "user command inside the refresh window");
				end
				if (expect_q.size() == 0) begin
					fault(2, "user command on the pins that was never sent");
				end else begin
					want = expect_q.pop_front();
					assert (pin_word == want)
						else value_error(2, "user_stream command", want, pin_word);
				end
			end
			default: begin
				fault(2, "mode register set after init");
			end
		endcase
	endtask

	always @(posedge CLK_n) begin
		if (RST) begin
			cycle <= cycle + 1;
		end else begin
			cycle <= 0;
		end
	end

	// pin monitor, outputs are stable at the falling edge
	always @(negedge CLK_n) begin
		pin_word = {cmd_pin, bank_pin, addr_pin};
		if (cycle > 0) begin
			if (credit_return) begin
				returned++;
			end
			if (cke_cycle < 0 && cke) begin
				cke_cycle = cycle;
				assert (cycle == ddr2_front_pkg::CKE_WAIT_CYCLES + 1) // plus pin register
					else value_error(0, "cke_wait rise cycle",
						ddr2_front_pkg::CKE_WAIT_CYCLES + 1, cycle);
			end
			if (in_refresh && arsr_cycle >= 0 &&
				cycle - arsr_cycle > ddr2_front_pkg::TRFC_CYCLES) begin
				in_refresh = 1'b0; // trfc window over
			end
			if (!ready_seen && ready) begin
				ready_seen = 1'b1;
				assert (step_idx == ddr2_front_pkg::INIT_STEPS)
					else value_error(1, "init_sequence step count",
						ddr2_front_pkg::INIT_STEPS, step_idx);
				assert (cycle - last_step == ddr2_front_pkg::INIT_SETTLE_CYCLES)
					else value_error(1, "init_sequence settle", ddr2_front_pkg::INIT_SETTLE_CYCLES,
						cycle - last_step);
			end
			if (cmd_pin != ddr2_front_pkg::NOOP) begin
				if (!ready_seen) begin
					check_init_step();
				end else begin
					check_user_side();
				end
			end
		end
	end

	a_noop_while_cke_low: assert property (
		@(posedge CLK_n) disable iff (!RST)
		!cke |-> cmd_pin == ddr2_front_pkg::NOOP
	) else fault(0, "command other than NOOP while cke is low");

	a_ready_holds: assert property (
		@(posedge CLK_n) disable iff (!RST)
		ready |=> ready
	) else fault(1, "ready fell after init");

	task automatic next_cycle();
		@(negedge CLK_n);
		user_valid = 1'b0;
		if (credit_return) begin
			credits++;
		end
		assert (credits <= ddr2_front_pkg::QUEUE_DEPTH)
			else value_error(3, "credit_count ceiling", ddr2_front_pkg::QUEUE_DEPTH, credits);
	endtask

	task automatic send_one();
		ddr2_front_pkg::ddr2_cmd_e c;
		assert (credits > 0) else fault(3, "command sent without a credit");
		case ($urandom % 4)
			0: c = ddr2_front_pkg::ACTV;
			1: c = ddr2_front_pkg::READ;
			2: c = ddr2_front_pkg::WRTE;
			default: c = ddr2_front_pkg::BTRM;
		endcase
		user_valid = 1'b1;
		user_cmd   = c;
		user_addr  = 14'($urandom);
		user_bank  = 3'($urandom);
		expect_q.push_back({c, user_bank, user_addr});
		credits--;
		sent++;
	endtask

	initial begin
		int n;
		int stall;
		void'($urandom(32'h2c8d_ffa0));
		RST        = 1'b0;
		user_valid = 1'b0;
		user_cmd   = ddr2_front_pkg::NOOP;
		user_addr  = '0;
		user_bank  = '0;
		credits    = ddr2_front_pkg::QUEUE_DEPTH;
		repeat (16) @(negedge CLK_n);
		assert (!cke && cmd_pin == ddr2_front_pkg::NOOP && !ready && !credit_return)
			else fault(0, "outputs not idle during reset");
		RST = 1'b1;

		n = 0;
		while (!ready && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!ready) begin
			fault(1, "timed out waiting for ready");
		end
		next_cycle();
		report_test(0, "cke_wait");
		report_test(1, "init_sequence");

		// random stream with random gaps
		for (int i = 0; i < STREAM_CYCLES; i++) begin
			next_cycle();
			if (credits > 0 && $urandom % 3 != 0) begin
				send_one();
			end
		end

		// burst lined up with a refresh so the queue stalls
		n = 0;
		while (cmd_pin != ddr2_front_pkg::PRCH && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (cmd_pin != ddr2_front_pkg::PRCH) begin
			fault(5, "timed out waiting for a refresh");
		end
		for (int i = 0; i < ddr2_front_pkg::QUEUE_DEPTH; i++) begin
			if (i > 0) begin
				next_cycle();
			end
			send_one();
		end
		stall = 0;
		next_cycle();
		while (credits == 0 && stall < WAIT_LIMIT) begin
			next_cycle();
			stall++;
		end
		if (credits == 0) begin
			fault(5, "timed out waiting for a credit after the burst");
		end
		assert (stall > ddr2_front_pkg::TRFC_CYCLES)
			else value_error(5, "burst_stall credit delay",
				ddr2_front_pkg::TRFC_CYCLES + 1, stall);
		for (int i = 0; i < EXTRA_CREDITS; i++) begin
			send_one();
			n = 0;
			do begin
				next_cycle();
				n++;
			end while (credits == 0 && n < WAIT_LIMIT);
			if (credits == 0) begin
				fault(5, "timed out waiting for a credit during the burst");
			end
		end

		n = 0;
		while ((credits != ddr2_front_pkg::QUEUE_DEPTH || expect_q.size() != 0) &&
			n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		next_cycle();
		if (expect_q.size() != 0) begin
			fault(2, "queued commands never reached the pins");
		end
		report_test(5, "burst_stall");
		report_test(2, "user_stream");
		assert (returned == sent) else value_error(3, "credit_count returns", sent, returned);
		assert (credits == ddr2_front_pkg::QUEUE_DEPTH)
			else value_error(3, "credit_count final", ddr2_front_pkg::QUEUE_DEPTH, credits);
		report_test(3, "credit_count");
		if (refreshes == 0) begin
			fault(4, "no refresh seen on the pins");
		end
		report_test(4, "refresh");

		$display("tests %0d, commands %0d, refreshes %0d, errors %0d",
			tests_done, sent, refreshes, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: ddr2_front.f
ddr2_front_pkg.sv
ddr2_cmd_if.sv
ddr2_initializer.sv
ddr2_refresh_timer.sv
ddr2_cmd_arbiter.sv
ddr2_front.sv
tb_clock_gen.sv
tb_ddr2_front.sv

// File: Makefile
TOP = tb_ddr2_front

all: run

build:
	verilator --binary --timing --assert -f ddr2_front.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

lint:
	verilator --lint-only -Wall --timing -f ddr2_front.f --top-module ddr2_front

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
